// File: source/gpio_pkg.sv
// GPIO shared definitions
package gpio_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned gpio_count = 16; // Pins on the block
  localparam int unsigned data_width = 32; // OBI data bus
  localparam int unsigned addr_width = 32; // OBI address bus
  localparam int unsigned id_width   = 4;  // Transaction id

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Byte offsets, one word each
  localparam logic [addr_width-1:0] dir_offset           = 32'h00;
  localparam logic [addr_width-1:0] en_offset            = 32'h04;
  localparam logic [addr_width-1:0] in_offset            = 32'h08; // Read only
  localparam logic [addr_width-1:0] out_offset           = 32'h0C;
  localparam logic [addr_width-1:0] toggle_offset        = 32'h10; // Write strobe, reads 0
  localparam logic [addr_width-1:0] intrpt_en_offset     = 32'h14;
  localparam logic [addr_width-1:0] intrpt_status_offset = 32'h18; // Clear on read
  localparam logic [addr_width-1:0] intrpt_edge_offset   = 32'h1C;

  localparam logic [data_width-1:0] unmapped_rdata = 32'hBADCAB1E; // Unmapped read pattern

  //////////////////////////////
  // Bus and per-pin types
  //////////////////////////////

  typedef struct packed {
    logic                    req;   // Request valid
    logic                    we;    // Write enable
    logic [data_width/8-1:0] be;    // Byte enables
    logic [addr_width-1:0]   addr;  // Byte address
    logic [data_width-1:0]   wdata;
    logic [id_width-1:0]     aid;   // Returned as rid
  } obi_req_t;

  typedef struct packed {
    logic                  gnt;    // Same cycle as req
    logic                  rvalid; // One cycle after grant
    logic [data_width-1:0] rdata;
    logic [id_width-1:0]   rid;
    logic                  err;
  } obi_rsp_t;

  // Register state seen by one pin
  typedef struct packed {
    logic dir;
    logic en;
    logic out;
    logic toggle;      // One-cycle strobe
    logic intrpt_en;
    logic intrpt_edge; // 1 rising edge, 0 high level
  } gpio_reg2hw_t;

  // Hardware updates from one pin
  typedef struct packed {
    logic sync_in;      // Synchronized, masked by en
    logic out;          // Toggled output value
    logic out_valid;
    logic intrpt;       // Interrupt condition
    logic intrpt_valid;
  } gpio_hw2reg_t;

endpackage

// File: source/gpio_reg_file.sv
// GPIO register bank
module gpio_reg_file (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  gpio_pkg::obi_req_t                                obi_req_i,
  output gpio_pkg::obi_rsp_t                                obi_rsp_o,
  output gpio_pkg::gpio_reg2hw_t [gpio_pkg::gpio_count-1:0] reg2hw_o,
  input  gpio_pkg::gpio_hw2reg_t [gpio_pkg::gpio_count-1:0] hw2reg_i,
  output logic                                              irq_o
);
  import gpio_pkg::*;

  // Stored registers, toggle is only a strobe
  typedef struct packed {
    logic [gpio_count-1:0] dir;
    logic [gpio_count-1:0] en;
    logic [gpio_count-1:0] in;
    logic [gpio_count-1:0] out;
    logic [gpio_count-1:0] intrpt_en;
    logic [gpio_count-1:0] intrpt;      // Status
    logic [gpio_count-1:0] intrpt_edge;
  } gpio_regs_t;

  // Request fields carried into the response phase
  typedef struct packed {
    logic                  we;
    logic [addr_width-1:0] addr;
    logic [id_width-1:0]   id;
  } rsp_phase_t;

  // Byte-masked field update
  function automatic logic [gpio_count-1:0] merge_bits(
    input logic [gpio_count-1:0] old_val,
    input logic [gpio_count-1:0] new_val,
    input logic [gpio_count-1:0] mask
  );
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  logic                  valid_q;        // Response pending
  logic                  w_err_d, w_err_q;
  rsp_phase_t            rsp_q;
  logic                  wr_req, rd_req;
  logic [gpio_count-1:0] wr_mask, wr_data;
  logic [gpio_count-1:0] toggle_strobe;
  logic [gpio_count-1:0] new_intrpt;     // Reported this cycle
  logic [data_width-1:0] rdata;
  logic                  rd_err;
  gpio_regs_t            reg_d, reg_q;
  gpio_regs_t            hw_reg;         // Registers after hardware updates

  //////////////////////////////
  // Bus phases
  //////////////////////////////

  assign wr_req  = obi_req_i.req & obi_req_i.we;  // Request phase
  assign rd_req  = valid_q & ~rsp_q.we;           // Response phase
  assign wr_data = obi_req_i.wdata[gpio_count-1:0];

  // Expand byte enables to pin bits
  always_comb begin
    for (int i = 0; i < gpio_count; i++) begin
      wr_mask[i] = obi_req_i.be[i/8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      w_err_q <= 1'b0;
    end else begin
      valid_q <= obi_req_i.req;
      w_err_q <= w_err_d;
    end
  end

  // Payload only, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rsp_q <= '{we: obi_req_i.we, addr: obi_req_i.addr, id: obi_req_i.aid};
    end
  end

  always_comb begin
    obi_rsp_o        = '0;
    obi_rsp_o.gnt    = obi_req_i.req;  // No back-pressure
    obi_rsp_o.rvalid = valid_q;
    obi_rsp_o.rdata  = rdata;
    obi_rsp_o.rid    = rsp_q.id;
    obi_rsp_o.err    = w_err_q | rd_err;
  end

  //////////////////////////////
  // Hardware side
  //////////////////////////////

  assign toggle_strobe = (wr_req && obi_req_i.addr == toggle_offset) ? (wr_mask & wr_data)
                                                                      : '0;

  always_comb begin
    for (int i = 0; i < gpio_count; i++) begin
      reg2hw_o[i].dir         = reg_q.dir[i];
      reg2hw_o[i].en          = reg_q.en[i];
      reg2hw_o[i].out         = reg_q.out[i];
      reg2hw_o[i].toggle      = toggle_strobe[i];
      reg2hw_o[i].intrpt_en   = reg_q.intrpt_en[i];
      reg2hw_o[i].intrpt_edge = reg_q.intrpt_edge[i];
    end
  end

  // Merge pin updates every cycle
  always_comb begin
    hw_reg = reg_q;
    for (int i = 0; i < gpio_count; i++) begin
      hw_reg.in[i]  = hw2reg_i[i].sync_in;
      if (hw2reg_i[i].out_valid) begin
        hw_reg.out[i] = hw2reg_i[i].out;  // Toggle result
      end
      new_intrpt[i] = hw2reg_i[i].intrpt_valid & hw2reg_i[i].intrpt;
    end
    hw_reg.intrpt = reg_q.intrpt | new_intrpt;  // Hardware only sets
  end

  //////////////////////////////
  // Write and read decode
  //////////////////////////////

  always_comb begin
    reg_d   = hw_reg;
    w_err_d = 1'b0;
    rdata   = '0;
    rd_err  = 1'b0;

    if (wr_req) begin
      case (obi_req_i.addr)
        dir_offset:         reg_d.dir         = merge_bits(hw_reg.dir, wr_data, wr_mask);
        en_offset:          reg_d.en          = merge_bits(hw_reg.en, wr_data, wr_mask);
        out_offset:         reg_d.out         = merge_bits(hw_reg.out, wr_data, wr_mask);
        toggle_offset:      ;                                 // Strobe only
        intrpt_en_offset:   reg_d.intrpt_en   = merge_bits(hw_reg.intrpt_en, wr_data, wr_mask);
        intrpt_edge_offset: reg_d.intrpt_edge = merge_bits(hw_reg.intrpt_edge, wr_data, wr_mask);
        default:            w_err_d           = 1'b1;         // Read only or unmapped
      endcase
    end

    if (rd_req) begin
      case (rsp_q.addr)
        dir_offset:         rdata = data_width'(reg_q.dir);
        en_offset:          rdata = data_width'(reg_q.en);
        in_offset:          rdata = data_width'(reg_q.in);
        out_offset:         rdata = data_width'(reg_q.out);
        toggle_offset:      rdata = '0;
        intrpt_en_offset:   rdata = data_width'(reg_q.intrpt_en);
        intrpt_status_offset: begin
          rdata        = data_width'(reg_q.intrpt);
          reg_d.intrpt = new_intrpt;  // Clear, keep fresh reports
        end
        intrpt_edge_offset: rdata = data_width'(reg_q.intrpt_edge);
        default: begin
          rdata  = unmapped_rdata;
          rd_err = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reg_q <= '0;
    end else begin
      reg_q <= reg_d;
    end
  end

  assign irq_o = |reg_q.intrpt;  // Straight from status

endmodule

// File: source/gpio_pin_ctrl.sv
// GPIO pin controller
module gpio_pin_ctrl (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  gpio_pkg::gpio_reg2hw_t [gpio_pkg::gpio_count-1:0] reg2hw_i,
  output gpio_pkg::gpio_hw2reg_t [gpio_pkg::gpio_count-1:0] hw2reg_o,
  input  logic [gpio_pkg::gpio_count-1:0]                   gpio_i,
  output logic [gpio_pkg::gpio_count-1:0]                   gpio_o,
  output logic [gpio_pkg::gpio_count-1:0]                   gpio_oe_o
);
  import gpio_pkg::*;

  // Input chain for all pins
  typedef struct packed {
    logic [gpio_count-1:0] meta;  // First flop, may go metastable
    logic [gpio_count-1:0] sync;  // Second flop, safe to use
    logic [gpio_count-1:0] prev;  // Sync delayed once, for edges
  } sync_chain_t;

  sync_chain_t           sync_q;
  logic [gpio_count-1:0] rise;        // Rising edge of sync
  logic [gpio_count-1:0] intrpt_cond; // Edge or level hit
  logic [gpio_count-1:0] intrpt_arm;  // en and intrpt_en

  //////////////////////////////
  // Input synchronizer
  //////////////////////////////

  // Reset keeps prev low so no false edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q.meta <= gpio_i;
      sync_q.sync <= sync_q.meta;
      sync_q.prev <= sync_q.sync;
    end
  end

  assign rise = sync_q.sync & ~sync_q.prev;

  //////////////////////////////
  // Per-pin logic
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < gpio_count; i++) begin
      intrpt_arm[i]  = reg2hw_i[i].en & reg2hw_i[i].intrpt_en;
      // Edge mode looks for 0 to 1, level mode for any high cycle
      intrpt_cond[i] = reg2hw_i[i].intrpt_edge ? rise[i] : sync_q.sync[i];
    end
  end

  always_comb begin
    for (int i = 0; i < gpio_count; i++) begin
      hw2reg_o[i].sync_in      = sync_q.sync[i] & reg2hw_i[i].en;  // Disabled reads 0
      hw2reg_o[i].out          = ~reg2hw_i[i].out;                 // Toggled value
      hw2reg_o[i].out_valid    = reg2hw_i[i].toggle;               // Only when strobed
      hw2reg_o[i].intrpt       = intrpt_cond[i];                   // Edge or level seen
      hw2reg_o[i].intrpt_valid = intrpt_arm[i];                    // Pin may interrupt
    end
  end

  //////////////////////////////
  // Pad drive
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < gpio_count; i++) begin
      gpio_oe_o[i] = reg2hw_i[i].dir & reg2hw_i[i].en;
      gpio_o[i]    = reg2hw_i[i].out & reg2hw_i[i].en;  // Low on disabled pins
    end
  end

endmodule

// File: source/gpio_top.sv
// GPIO block top level
module gpio_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  gpio_pkg::obi_req_t              obi_req_i,
  output gpio_pkg::obi_rsp_t              obi_rsp_o,
  input  logic [gpio_pkg::gpio_count-1:0] gpio_i,
  output logic [gpio_pkg::gpio_count-1:0] gpio_o,
  output logic [gpio_pkg::gpio_count-1:0] gpio_oe_o,
  output logic                            irq_o
);
  import gpio_pkg::*;

  // Register to pin traffic, one entry per pin
  gpio_reg2hw_t [gpio_count-1:0] reg2hw;
  gpio_hw2reg_t [gpio_count-1:0] hw2reg;

  //////////////////////////////
  // Bus side
  //////////////////////////////

  gpio_reg_file i_reg_file (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .obi_req_i (obi_req_i),
    .obi_rsp_o (obi_rsp_o),
    .reg2hw_o  (reg2hw),
    .hw2reg_i  (hw2reg),
    .irq_o     (irq_o)      // OR of status
  );

  //////////////////////////////
  // Pad side
  //////////////////////////////

  gpio_pin_ctrl i_pin_ctrl (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .reg2hw_i  (reg2hw),
    .hw2reg_o  (hw2reg),
    .gpio_i    (gpio_i),    // Raw pad inputs
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

endmodule

// File: verification/gpio_tb_sva.sv
// GPIO protocol and pad checks
module gpio_tb_sva (
  input logic                            clk_i,
  input logic                            rst_i,
  input gpio_pkg::obi_req_t              obi_req_i,
  input gpio_pkg::obi_rsp_t              obi_rsp_i,
  input logic [gpio_pkg::gpio_count-1:0] gpio_oe_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import gpio_pkg::*;

  int                    fail_count = 0;  // Failed assertions so far
  logic [gpio_count-1:0] wr_mask;         // Byte enables per pin
  logic [gpio_count-1:0] wr_bits;
  logic [gpio_count-1:0] dir_q, en_q;     // Tracked from bus writes
  logic [gpio_count-1:0] dir_en;          // Expected output enables

  assign wr_mask = {{8{obi_req_i.be[1]}}, {8{obi_req_i.be[0]}}};
  assign wr_bits = obi_req_i.wdata[gpio_count-1:0] & wr_mask;
  assign dir_en  = dir_q & en_q;

  // Follow dir and en writes as seen on the bus
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dir_q <= '0;
      en_q  <= '0;
    end else if (obi_req_i.req && obi_req_i.we) begin
      if (obi_req_i.addr == dir_offset) begin
        dir_q <= (dir_q & ~wr_mask) | wr_bits;
      end
      if (obi_req_i.addr == en_offset) begin
        en_q <= (en_q & ~wr_mask) | wr_bits;
      end
    end
  end

  // Grant in the request cycle, no back-pressure
  gnt_eq_req: assert property (@(posedge clk_i) obi_rsp_i.gnt == obi_req_i.req)
    else begin
      $error("gnt differs from req");
      fail_count++;
    end

  rvalid_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rsp_i.rvalid == $past(obi_req_i.req))  // Exactly one response per grant
    else begin
      $error("rvalid does not follow req by one cycle");
      fail_count++;
    end

  oe_eq_dir_en: assert property (@(posedge clk_i) disable iff (rst_i) gpio_oe_i == dir_en)
    else begin
      $error("gpio_oe_o differs from dir and en");
      fail_count++;
    end

  no_rvalid_reset: assert property (@(posedge clk_i) rst_i |=> !obi_rsp_i.rvalid)
    else begin
      $error("rvalid seen during or just after reset");
      fail_count++;
    end

endmodule

// File: verification/gpio_tb.sv
// GPIO block testbench
module gpio_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import gpio_pkg::*;

  localparam int unsigned bus_ops    = 61;                // Reads and writes over all tests
  localparam int unsigned max_cycles = bus_ops * 20 + 5;  // Plus reset
  localparam logic [addr_width-1:0] rw_offsets [5] =
    '{dir_offset, en_offset, out_offset, intrpt_en_offset, intrpt_edge_offset};

  // Expected register contents
  typedef struct packed {
    logic [gpio_count-1:0] dir;
    logic [gpio_count-1:0] en;
    logic [gpio_count-1:0] in;
    logic [gpio_count-1:0] out;
    logic [gpio_count-1:0] ien;
    logic [gpio_count-1:0] status;
    logic [gpio_count-1:0] edge_sel;
  } shadow_t;

  logic                  clk_i;
  logic                  rst_i;
  obi_req_t              obi_req_i;
  obi_rsp_t              obi_rsp_o;
  logic [gpio_count-1:0] gpio_i, gpio_o, gpio_oe_o;
  logic                  irq_o;
  shadow_t               sh;
  logic [data_width-1:0] exp_rdata;  // Response of the last granted request
  logic                  exp_err;
  logic [id_width-1:0]   exp_rid;
  int                    seed        = 97921;

  gpio_top i_gpio_top (.*);

  bind gpio_top gpio_tb_sva i_tb_sva (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .obi_req_i (obi_req_i),
    .obi_rsp_i (obi_rsp_o),
    .gpio_oe_i (gpio_oe_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_val);
    $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp_val);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    assert (got == exp_val) else report_mismatch(name, got, exp_val);
  endtask

  // Response checks, one cycle after each grant
  rdata_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rsp_o.rvalid |-> obi_rsp_o.rdata == exp_rdata)
    else report_mismatch("rdata", $sampled(obi_rsp_o.rdata), $sampled(exp_rdata));
  err_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rsp_o.rvalid |-> obi_rsp_o.err == exp_err)
    else report_mismatch("err", 32'($sampled(obi_rsp_o.err)), 32'($sampled(exp_err)));
  rid_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rsp_o.rvalid |-> obi_rsp_o.rid == exp_rid)
    else report_mismatch("rid", 32'($sampled(obi_rsp_o.rid)), 32'($sampled(exp_rid)));

  always @(negedge clk_i) begin
    if (i_gpio_top.i_tb_sva.fail_count != 0) begin
      $display("A bound protocol or pad-drive assertion failed");
      stop_on_failure();
    end
  end

  initial begin
    repeat (max_cycles) @(posedge clk_i);
    $display("Timeout: tests did not finish within %0d cycles", max_cycles);
    stop_on_failure();
  end

  //////////////////////////////
  // Bus and pin tasks
  //////////////////////////////

  function automatic logic [data_width-1:0] expected_read(input logic [addr_width-1:0] addr);
    case (addr)
      dir_offset:           return data_width'(sh.dir);
      en_offset:            return data_width'(sh.en);
      in_offset:            return data_width'(sh.in);
      out_offset:           return data_width'(sh.out);
      toggle_offset:        return '0;                  // Strobe only
      intrpt_en_offset:     return data_width'(sh.ien);
      intrpt_status_offset: return data_width'(sh.status);
      intrpt_edge_offset:   return data_width'(sh.edge_sel);
      default:              return unmapped_rdata;
    endcase
  endfunction

  // One request, shadow updated at the grant edge
  task automatic bus_access(input logic is_write, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data, input logic [3:0] byte_en);
    logic [gpio_count-1:0] bmask;
    logic [gpio_count-1:0] wbits;
    logic [id_width-1:0]   aid;
    logic                  mapped;
    bmask  = {{8{byte_en[1]}}, {8{byte_en[0]}}};  // Bytes 2 and 3 hold no pins
    wbits  = data[gpio_count-1:0] & bmask;
    aid    = id_width'($random(seed));
    mapped = addr inside {dir_offset, en_offset, in_offset, out_offset, toggle_offset,
                          intrpt_en_offset, intrpt_status_offset, intrpt_edge_offset};
    @(posedge clk_i);
    obi_req_i <= '{req: 1'b1, we: is_write, be: byte_en, addr: addr, wdata: data, aid: aid};
    @(posedge clk_i);
    obi_req_i.req <= 1'b0;
    exp_rid       <= aid;
    exp_rdata     <= is_write ? '0 : expected_read(addr);
    exp_err       <= !mapped || (is_write && addr inside {in_offset, intrpt_status_offset});
    if (is_write) begin
      case (addr)
        dir_offset:         sh.dir      = (sh.dir & ~bmask) | wbits;
        en_offset:          sh.en       = (sh.en & ~bmask) | wbits;
        out_offset:         sh.out      = (sh.out & ~bmask) | wbits;
        toggle_offset:      sh.out      = sh.out ^ wbits;  // Strobed bits flip
        intrpt_en_offset:   sh.ien      = (sh.ien & ~bmask) | wbits;
        intrpt_edge_offset: sh.edge_sel = (sh.edge_sel & ~bmask) | wbits;
        default: ;
      endcase
    end
  endtask

  task automatic read_reg(input logic [addr_width-1:0] addr);
    bus_access(1'b0, addr, '0, 4'hF);
  endtask

  // Covers both synchronizer flops and the in register
  task automatic drive_pins(input logic [gpio_count-1:0] value);
    @(posedge clk_i);
    gpio_i <= value;
    repeat (3) @(posedge clk_i);
    sh.in = value & sh.en;
  endtask

  task automatic check_pads();
    @(negedge clk_i);
    check_value("gpio_oe_o", 32'(gpio_oe_o), 32'(sh.dir & sh.en));
    check_value("gpio_o", 32'(gpio_o), 32'(sh.out & sh.en));
  endtask

  task automatic check_irq();
    @(negedge clk_i);
    check_value("irq_o", 32'(irq_o), 32'(|sh.status));
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [addr_width-1:0] addr;
    logic [gpio_count-1:0] pins;
    logic [gpio_count-1:0] ien;
    logic [gpio_count-1:0] edge_sel;
    obi_req_i = '0;
    gpio_i    = '0;
    rst_i     = 1'b1;
    sh        = '0;
    exp_rdata = '0;
    exp_err   = 1'b0;
    exp_rid   = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int i = 0; i < 10; i++) begin  // Byte-enabled readback
      addr = rw_offsets[{$random(seed)} % 5];
      bus_access(1'b1, addr, $random(seed), 4'($random(seed)));
      read_reg(addr);
    end
    read_reg(intrpt_status_offset);  // Quiet pins, still zero

    for (int i = 0; i < 3; i++) begin  // dir, en, out
      bus_access(1'b1, rw_offsets[i], $random(seed), 4'hF);
      check_pads();
    end
    for (int i = 0; i < 3; i++) begin
      bus_access(1'b1, toggle_offset, $random(seed), 4'($random(seed)));
      check_pads();
      read_reg(out_offset);
      read_reg(toggle_offset);
    end

    // Input path, no interrupts armed
    bus_access(1'b1, intrpt_en_offset, '0, 4'hF);
    bus_access(1'b1, en_offset, $random(seed), 4'hF);
    for (int i = 0; i < 6; i++) begin
      drive_pins(16'($random(seed)));
      read_reg(in_offset);
    end
    drive_pins('0);

    // Interrupts, pin 0 level mode and pin 1 edge mode at least
    pins     = 16'($random(seed)) | 16'h3;
    ien      = 16'($random(seed)) | 16'h3;
    edge_sel = (16'($random(seed)) & ~16'h3) | 16'h2;
    bus_access(1'b1, en_offset, $random(seed) | 32'h3, 4'hF);
    bus_access(1'b1, intrpt_edge_offset, 32'(edge_sel), 4'hF);
    bus_access(1'b1, intrpt_en_offset, 32'(ien), 4'hF);
    check_irq();
    drive_pins(pins);
    sh.status = pins & ien & sh.en;
    check_irq();
    read_reg(intrpt_status_offset);
    sh.status = sh.status & ~edge_sel;  // Level pins set again at once
    read_reg(intrpt_status_offset);
    drive_pins('0);
    read_reg(intrpt_status_offset);     // Held from before the pins fell
    sh.status = '0;
    read_reg(intrpt_status_offset);
    check_irq();

    // Error responses, registers unchanged
    read_reg(32'h20);
    read_reg(32'h3C);
    bus_access(1'b1, in_offset, $random(seed), 4'hF);
    bus_access(1'b1, intrpt_status_offset, 32'hFFFF, 4'hF);
    bus_access(1'b1, 32'h24, $random(seed), 4'hF);
    for (int i = 0; i < 8; i++) begin
      read_reg(addr_width'(i * 4));
    end

    repeat (2) @(posedge clk_i);  // Last response checked
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sources.f
source/gpio_pkg.sv
source/gpio_reg_file.sv
source/gpio_pin_ctrl.sv
source/gpio_top.sv
verification/gpio_tb_sva.sv
verification/gpio_tb.sv
